// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_synapse_weight_mem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing --timescale 1ns/100ps
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== fifo_level_counter.sv ====
// queue occupancy counter with full and empty decode
`timescale 1ns/100ps
`default_nettype none

module fifo_level_counter
(
	input  wire  clk_i,
	input  wire  rst_n_i,
	input  wire  clr_i,
	input  wire  push_i,
	input  wire  pop_i,
	output logic empty_o,
	output logic full_o
);

	logic [syn_pkg::FIFO_LEVEL_W-1:0] level_q;

	// push and pop together leave the level unchanged
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			level_q <= '0;
		else if (clr_i)
			level_q <= '0;
		else if (push_i && !pop_i)
			level_q <= level_q + 1'b1;
		else if (pop_i && !push_i)
			level_q <= level_q - 1'b1;
	end

	assign empty_o = (level_q == '0);

	// top bit is only ever set at exactly the depth
	assign full_o = level_q[syn_pkg::FIFO_AW];

	a_level_bound: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		level_q <= (1 << syn_pkg::FIFO_AW)
	) else $error("queue level above depth");

endmodule

`default_nettype wire

// ==== recall_fifo.sv ====
// first-word-fall-through queue of scaled weights and codes
// storage, read and write pointers, level counter instance
`timescale 1ns/100ps
`default_nettype none

module recall_fifo
(
	input  wire                        clk_i,
	input  wire                        rst_n_i,
	input  wire                        clr_i,
	input  wire                        push_i,
	input  wire [syn_pkg::FIFO_W-1:0]  push_data_i,
	input  wire                        pop_i,
	output logic [syn_pkg::FIFO_W-1:0] head_o,
	output logic                       empty_o,
	output logic                       full_o
);

	logic [syn_pkg::FIFO_W-1:0]  mem [1 << syn_pkg::FIFO_AW];
	logic [syn_pkg::FIFO_AW-1:0] wr_ptr_q;
	logic [syn_pkg::FIFO_AW-1:0] rd_ptr_q;

	always_ff @(posedge clk_i)
	begin
		if (push_i)
			mem[wr_ptr_q] <= push_data_i;
	end

	// pointers wrap naturally at the power-of-two depth
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_i)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	// head falls through as soon as the write lands
	assign head_o = mem[rd_ptr_q];

	fifo_level_counter u_level
	(
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.clr_i   (clr_i),
		.push_i  (push_i),
		.pop_i   (pop_i),
		.empty_o (empty_o),
		.full_o  (full_o)
	);

	a_no_push_full: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(push_i && full_o && !clr_i)
	) else $error("recall pushed into a full queue");

	a_no_pop_empty: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(pop_i && empty_o && !clr_i)
	) else $error("learning popped an empty queue");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
syn_pkg.sv
fifo_level_counter.sv
recall_fifo.sv
weight_bank_array.sv
weight_scaler.sv
synapse_weight_mem.sv
tb_synapse_weight_mem.sv

// ==== syn_pkg.sv ====
// widths, depths and timing of the synapse weight store
// synapse address union with flat and bank/offset views
`default_nettype none

package syn_pkg;

	// synapse address, neuron bits above axon bits
	localparam int SYN_ADDR_W = 16;
	localparam int BANK_SEL_W = 2;
	localparam int BANK_OFS_W = 14;
	localparam int NUM_BANKS  = 4;

	// stored and scaled weights
	localparam int WEIGHT_W = 12;
	localparam int SCALED_W = 16;
	localparam int SCALE_W  = 2;

	// doubled depth, recall may run a whole neuron ahead of learning
	localparam int FIFO_AW      = 9;
	localparam int FIFO_W       = SCALED_W + SCALE_W;
	localparam int FIFO_LEVEL_W = FIFO_AW + 1;

	// pop to write-back distance in cycles
	localparam int LEARN_DELAY = 4;

	typedef union packed
	{
		logic [SYN_ADDR_W-1:0] flat;
		struct packed
		{
			logic [BANK_SEL_W-1:0] bank;
			logic [BANK_OFS_W-1:0] offset;
		} f;
	} syn_addr_u;

endpackage

`default_nettype wire

// ==== synapse_weight_mem.sv ====
// synapse weight store top level
// bank array, recall and write-back scaler, recall-to-learn queue
`timescale 1ns/100ps
`default_nettype none

module synapse_weight_mem
(
	input  wire                            clk_i,
	input  wire                            rst_n_i,
	input  wire                            start_i,
	input  wire                            recall_rd_en_i,
	input  wire [syn_pkg::SYN_ADDR_W-1:0]  recall_addr_i,
	input  wire [syn_pkg::SCALE_W-1:0]     axon_scale_i,
	output logic [syn_pkg::SCALED_W-1:0]   recall_weight_o,
	input  wire                            learn_rd_en_i,
	output logic [syn_pkg::SCALED_W-1:0]   learn_data_o,
	output logic                           learn_empty_o,
	output logic                           learn_full_o,
	input  wire                            wb_wr_en_i,
	input  wire [syn_pkg::SYN_ADDR_W-1:0]  wb_addr_i,
	input  wire [syn_pkg::SCALED_W-1:0]    wb_data_i
);

	syn_pkg::syn_addr_u           recall_addr;
	syn_pkg::syn_addr_u           wb_addr;
	logic [syn_pkg::WEIGHT_W-1:0] bank_rd_weight;
	logic [syn_pkg::WEIGHT_W-1:0] wb_weight;
	logic                         rd_valid;
	logic [syn_pkg::FIFO_W-1:0]   fifo_head;
	logic [syn_pkg::SCALE_W-1:0]  pop_scale;

	assign recall_addr.flat = recall_addr_i;
	assign wb_addr.flat     = wb_addr_i;

	weight_bank_array u_banks
	(
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.rd_en_i     (recall_rd_en_i),
		.rd_addr_i   (recall_addr),
		.wr_en_i     (wb_wr_en_i),
		.wr_addr_i   (wb_addr),
		.wr_weight_i (wb_weight),
		.rd_weight_o (bank_rd_weight),
		.rd_valid_o  (rd_valid)
	);

	weight_scaler u_scaler
	(
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.recall_weight_i (bank_rd_weight),
		.scale_i         (axon_scale_i),
		.scaled_o        (recall_weight_o),
		.pop_i           (learn_rd_en_i),
		.pop_scale_i     (pop_scale),
		.wb_data_i       (wb_data_i),
		.wb_weight_o     (wb_weight)
	);

	// entry keeps the code beside the weight for the write-back
	recall_fifo u_queue
	(
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.clr_i       (start_i),
		.push_i      (rd_valid),
		.push_data_i ({recall_weight_o, axon_scale_i}),
		.pop_i       (learn_rd_en_i),
		.head_o      (fifo_head),
		.empty_o     (learn_empty_o),
		.full_o      (learn_full_o)
	);

	assign learn_data_o = fifo_head[syn_pkg::FIFO_W-1:syn_pkg::SCALE_W];
	assign pop_scale    = fifo_head[syn_pkg::SCALE_W-1:0];

endmodule

`default_nettype wire

// ==== tb_tasks.svh ====
// reference scale-up and scale-down, value check
// drive tasks for write-back, recall, burst, pop and clear
// directed tests for banks, scaling, queue order, write-back, full/clear
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [15:0] scale_up(input logic [11:0] w, input logic [1:0] c);
	logic signed [31:0] v;
	v = {{20{w[11]}}, w};
	// code 3 multiplies by 16, the others by 2**code
	v = v * ((c == 2'd3) ? 16 : (1 << c));
	return v[15:0];
endfunction

function automatic logic [11:0] scale_down(input logic [15:0] d, input logic [1:0] c);
	logic [31:0] v;
	v = {16'h0000, d} >> ((c == 2'd3) ? 4 : int'(c));
	return v[11:0];
endfunction

task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
	assert (got === exp)
	else
	begin
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		value_errors++;
	end
endtask

task automatic write_weight(input logic [15:0] addr, input logic [15:0] data,
	input logic [1:0] c);
	wb_wr_en_i = 1'b1;
	wb_addr_i = addr;
	wb_data_i = data;
	@(posedge clk_i);
	#1;
	wb_wr_en_i = 1'b0;
	model[addr] = scale_down(data, c);
endtask

// code is applied in the cycle after the strobe, when the push happens
task automatic recall_check(input logic [15:0] addr, input logic [1:0] c);
	logic [15:0] exp;
	exp = scale_up(model[addr], c);
	recall_rd_en_i = 1'b1;
	recall_addr_i = addr;
	@(posedge clk_i);
	#1;
	recall_rd_en_i = 1'b0;
	axon_scale_i = c;
	@(negedge clk_i);
	check_value("recall_weight_o", recall_weight_o, exp);
	exp_q.push_back(exp);
	@(posedge clk_i);
	#1;
endtask

task automatic recall_burst(input int n);
	logic [31:0] r;
	logic [1:0]  c;
	logic [15:0] a;
	for (int i = 0; i <= n; i++)
	begin
		recall_rd_en_i = (i < n);
		if (i > 0)
			axon_scale_i = c;
		if (i < n)
		begin
			r = $random(seed);
			c = r[1:0];
			a = addr_list[i % addr_list.size()];
			recall_addr_i = a;
			exp_q.push_back(scale_up(model[a], c));
		end
		@(posedge clk_i);
		#1;
	end
endtask

task automatic pop_check();
	logic [15:0] exp;
	if (exp_q.size() == 0)
	begin
		$display("pop at %0t with no entry left in the reference queue", $time);
		other_errors++;
		return;
	end
	exp = exp_q.pop_front();
	learn_rd_en_i = 1'b1;
	@(negedge clk_i);
	check_value("learn_empty_o", 16'(learn_empty_o), 16'd0);
	check_value("learn_data_o", learn_data_o, exp);
	@(posedge clk_i);
	#1;
	learn_rd_en_i = 1'b0;
endtask

task automatic clear_queue();
	start_i = 1'b1;
	@(posedge clk_i);
	#1;
	start_i = 1'b0;
	exp_q.delete();
endtask

// same offset in all four banks, delay line still at code 0
task automatic bank_decode_test();
	logic [31:0] r;
	logic [31:0] d;
	logic [15:0] a;
	for (int k = 0; k < 6; k++)
	begin
		r = $random(seed);
		for (int b = 0; b < 4; b++)
		begin
			d = $random(seed);
			a = {b[1:0], r[13:0]};
			addr_list.push_back(a);
			write_weight(a, d[15:0], 2'd0);
		end
	end
	foreach (addr_list[i])
		recall_check(addr_list[i], 2'd0);
endtask

task automatic recall_scaling_test();
	write_weight(16'h0123, 16'h05a3, 2'd0);
	write_weight(16'hc321, 16'hfa5c, 2'd0);
	for (int c = 0; c < 4; c++)
	begin
		recall_check(16'h0123, c[1:0]);
		recall_check(16'hc321, c[1:0]);
		recall_check(addr_list[c], c[1:0]);
	end
endtask

task automatic queue_order_test();
	clear_queue();
	recall_burst(8);
	for (int i = 0; i < 8; i++)
		pop_check();
	@(negedge clk_i);
	check_value("learn_empty_o", 16'(learn_empty_o), 16'd1);
	@(posedge clk_i);
	#1;
endtask

// write lands LEARN_DELAY edges after the pop edge
task automatic writeback_test();
	logic [31:0] r;
	for (int c = 0; c < 4; c++)
	begin
		r = $random(seed);
		clear_queue();
		recall_check(addr_list[c + 4], c[1:0]);
		pop_check();
		repeat (syn_pkg::LEARN_DELAY - 1) @(posedge clk_i);
		#1;
		write_weight(r[31:16], r[15:0], c[1:0]);
		recall_check(r[31:16], 2'd0);
	end
endtask

task automatic full_clear_test();
	clear_queue();
	recall_burst(1 << syn_pkg::FIFO_AW);
	@(negedge clk_i);
	check_value("learn_full_o", 16'(learn_full_o), 16'd1);
	@(posedge clk_i);
	#1;
	clear_queue();
	@(negedge clk_i);
	check_value("learn_empty_o", 16'(learn_empty_o), 16'd1);
	check_value("learn_full_o", 16'(learn_full_o), 16'd0);
	@(posedge clk_i);
	#1;
	recall_check(addr_list[0], 2'd3);
	pop_check();
endtask

`endif

// ==== tb_synapse_weight_mem.sv ====
// testbench for the synapse weight store
// clock, reset, watchdog, DUT instance, reference model and closing report
`timescale 1ns/100ps
`default_nettype none

module tb_synapse_weight_mem;

	localparam int CLK_PERIOD = 10;
	// bank fill, scaling, burst, write-back and full tests, plus margin
	localparam int TEST_CYCLES = 72 + 26 + 19 + 40 + 520 + 100;

	logic                             clk_i;
	logic                             rst_n_i;
	logic                             start_i;
	logic                             recall_rd_en_i;
	logic [syn_pkg::SYN_ADDR_W-1:0]   recall_addr_i;
	logic [syn_pkg::SCALE_W-1:0]      axon_scale_i;
	logic [syn_pkg::SCALED_W-1:0]     recall_weight_o;
	logic                             learn_rd_en_i;
	logic [syn_pkg::SCALED_W-1:0]     learn_data_o;
	logic                             learn_empty_o;
	logic                             learn_full_o;
	logic                             wb_wr_en_i;
	logic [syn_pkg::SYN_ADDR_W-1:0]   wb_addr_i;
	logic [syn_pkg::SCALED_W-1:0]     wb_data_i;

	// stored weights by flat address, and the expected queue contents
	logic [syn_pkg::WEIGHT_W-1:0]   model [logic [syn_pkg::SYN_ADDR_W-1:0]];
	logic [syn_pkg::SYN_ADDR_W-1:0] addr_list [$];
	logic [syn_pkg::SCALED_W-1:0]   exp_q [$];
	integer                         seed = 32'h577bf801;
	int                             value_errors = 0;
	int                             other_errors = 0;

	synapse_weight_mem dut_i (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	initial
	begin
		#(TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, test sequence did not finish", TEST_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		rst_n_i = 1'b0;
		start_i = 1'b0;
		recall_rd_en_i = 1'b0;
		recall_addr_i = '0;
		axon_scale_i = '0;
		learn_rd_en_i = 1'b0;
		wb_wr_en_i = 1'b0;
		wb_addr_i = '0;
		wb_data_i = '0;
		repeat (3) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		@(negedge clk_i);
		check_value("learn_empty_o", 16'(learn_empty_o), 16'd1);
		check_value("learn_full_o", 16'(learn_full_o), 16'd0);
		@(posedge clk_i);
		#1;
		bank_decode_test();
		recall_scaling_test();
		queue_order_test();
		writeback_test();
		full_clear_test();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	`include "tb_tasks.svh"

endmodule

`default_nettype wire

// ==== weight_bank_array.sv ====
// banked weight storage
// per-bank write and read decode, registered read offsets
// registered bank select for the output mux
`timescale 1ns/100ps
`default_nettype none

module weight_bank_array
(
	input  wire                              clk_i,
	input  wire                              rst_n_i,
	input  wire                              rd_en_i,
	input  wire syn_pkg::syn_addr_u          rd_addr_i,
	input  wire                              wr_en_i,
	input  wire syn_pkg::syn_addr_u          wr_addr_i,
	input  wire [syn_pkg::WEIGHT_W-1:0]      wr_weight_i,
	output logic [syn_pkg::WEIGHT_W-1:0]     rd_weight_o,
	output logic                             rd_valid_o
);

	logic [syn_pkg::WEIGHT_W-1:0]   bank_dout [syn_pkg::NUM_BANKS];
	logic [syn_pkg::BANK_SEL_W-1:0] rd_sel_q;

	genvar b;
	generate
		for (b = 0; b < syn_pkg::NUM_BANKS; b++)
		begin : g_bank
			logic [syn_pkg::WEIGHT_W-1:0]   mem [1 << syn_pkg::BANK_OFS_W];
			logic [syn_pkg::BANK_OFS_W-1:0] rd_ofs_q;
			logic                           rd_hit;
			logic                           wr_hit;

			// bank field picks which memory sees the strobe
			assign rd_hit = rd_en_i && (int'(rd_addr_i.f.bank) == b);
			assign wr_hit = wr_en_i && (int'(wr_addr_i.f.bank) == b);

			always_ff @(posedge clk_i)
			begin
				if (rd_hit)
					rd_ofs_q <= rd_addr_i.f.offset;
				if (wr_hit)
					mem[wr_addr_i.f.offset] <= wr_weight_i;
			end

			assign bank_dout[b] = mem[rd_ofs_q];
		end
	endgenerate

	// select follows the last strobe, so the output holds between recalls
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_sel_q   <= '0;
			rd_valid_o <= 1'b0;
		end
		else
		begin
			rd_valid_o <= rd_en_i;
			if (rd_en_i)
				rd_sel_q <= rd_addr_i.f.bank;
		end
	end

	assign rd_weight_o = bank_dout[rd_sel_q];

endmodule

`default_nettype wire

// ==== weight_scaler.sv ====
// recall scale-up of stored weights by the axon code
// write-back scale-down using a delayed popped code
`timescale 1ns/100ps
`default_nettype none

module weight_scaler
(
	input  wire                          clk_i,
	input  wire                          rst_n_i,
	input  wire [syn_pkg::WEIGHT_W-1:0]  recall_weight_i,
	input  wire [syn_pkg::SCALE_W-1:0]   scale_i,
	output logic [syn_pkg::SCALED_W-1:0] scaled_o,
	input  wire                          pop_i,
	input  wire [syn_pkg::SCALE_W-1:0]   pop_scale_i,
	input  wire [syn_pkg::SCALED_W-1:0]  wb_data_i,
	output logic [syn_pkg::WEIGHT_W-1:0] wb_weight_o
);

	logic [syn_pkg::SCALED_W-1:0] weight_ext;
	logic [syn_pkg::SCALE_W-1:0]  code_q [syn_pkg::LEARN_DELAY];

	assign weight_ext = {{(syn_pkg::SCALED_W - syn_pkg::WEIGHT_W)
		{recall_weight_i[syn_pkg::WEIGHT_W-1]}}, recall_weight_i};

	always_comb
	begin
		case (scale_i)
			2'd0: scaled_o = weight_ext;
			2'd1: scaled_o = weight_ext << 1;
			2'd2: scaled_o = weight_ext << 2;
			// largest code pushes every sign bit out
			default: scaled_o = weight_ext << 4;
		endcase
	end

	// code of each pop walks down the line; idle cycles insert code 0
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < syn_pkg::LEARN_DELAY; i++)
				code_q[i] <= '0;
		end
		else
		begin
			code_q[0] <= pop_i ? pop_scale_i : '0;
			for (int i = 1; i < syn_pkg::LEARN_DELAY; i++)
				code_q[i] <= code_q[i-1];
		end
	end

	always_comb
	begin
		case (code_q[syn_pkg::LEARN_DELAY-1])
			2'd0: wb_weight_o = wb_data_i[syn_pkg::WEIGHT_W-1:0];
			2'd1: wb_weight_o = wb_data_i[syn_pkg::WEIGHT_W:1];
			2'd2: wb_weight_o = wb_data_i[syn_pkg::WEIGHT_W+1:2];
			default: wb_weight_o = wb_data_i[syn_pkg::SCALED_W-1:4];
		endcase
	end

endmodule

`default_nettype wire
